// File: source/gem_link_pkg.sv
`default_nettype none

package gem_link_pkg;

   // --------------------
   // Widths
   // --------------------

   // Cluster payload carried by one link per frame
   localparam int unsigned PAYLOAD_W = 56;
   // Transmit word and its char-is-K flags
   localparam int unsigned WORD_W = 16;
   localparam int unsigned K_W = 2;
   // Words sent per bunch crossing
   localparam int unsigned WORDS_PER_FRAME = 4;
   localparam int unsigned FRAME_IDX_W = $clog2(WORDS_PER_FRAME);

   // --------------------
   // 8b10b K-codes
   // --------------------

   localparam logic [7:0] K_BC0 = 8'h1C;
   localparam logic [7:0] K_RESYNC = 8'h3C;
   localparam logic [7:0] K_OVERFLOW = 8'hFC;
   // Bunch sequence codes, picked by the bunch counter LSBs
   localparam logic [7:0] K_SEQ0 = 8'hBC;
   localparam logic [7:0] K_SEQ1 = 8'hF7;
   localparam logic [7:0] K_SEQ2 = 8'hFB;
   localparam logic [7:0] K_SEQ3 = 8'hFD;

   // Idle word while links are down, low byte is a comma
   localparam logic [WORD_W-1:0] IDLE_WORD = 16'hFFFC;
   // K flags for a word with a K char in the low byte
   localparam logic [K_W-1:0] K_FLAGS_LEAD = 2'b01;
   // K flags for a pure data word
   localparam logic [K_W-1:0] K_FLAGS_DATA = 2'b00;

   // --------------------
   // Transmit word views
   // --------------------

   // Frame word 0 layout
   typedef struct packed {
      logic [7:0] payload;
      logic [7:0] sep;
   } tx_lead_t;

   // Whole word for data and idle, lead view for the separator word
   typedef union packed {
      logic [WORD_W-1:0] raw;
      tx_lead_t lead;
   } tx_word_t;

endpackage

`default_nettype wire

// File: source/link_startup_seq.sv
`timescale 1ns/10ps
`default_nettype none

module link_startup_seq #(
   parameter int unsigned N_LINKS = 4,
   parameter int unsigned MGT_RESET_STEP = 20,
   parameter int unsigned TXRESET_CNT = 110,
   parameter int unsigned DONE_CNT = 130,
   parameter int unsigned ALLOW_RETRY = 0
) (
   input  logic               clock_40,
   input  logic               arst_n_i,
   input  logic [N_LINKS-1:0] mgt_reset_i,
   input  logic               txreset_i,
   input  logic               links_ready_i,
   output logic [N_LINKS-1:0] mgt_reset_o,
   output logic               txreset_o,
   output logic               startup_done_o
);

   // Counter saturates one past the done threshold
   localparam int unsigned CNT_W = $clog2(DONE_CNT + 2);
   localparam logic [CNT_W-1:0] CNT_TOP = CNT_W'(DONE_CNT + 1);

   logic [CNT_W-1:0] startup_cnt;
   // Zero extended copy for compares against the 32 bit thresholds
   logic [31:0] cnt_ext;
   logic retry;

   // --------------------
   // Power-up counter
   // --------------------

   // Restart when startup finished but the links never came up
   assign retry = (ALLOW_RETRY != 0) && startup_done_o && !links_ready_i;

   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         startup_cnt <= '0;
      end else if (retry) begin
         startup_cnt <= '0;
      end else if (startup_cnt != CNT_TOP) begin
         startup_cnt <= startup_cnt + 1'b1;
      end
   end

   assign cnt_ext = 32'(startup_cnt);

   // --------------------
   // Threshold decodes
   // --------------------

   // Staggered release, link l leaves reset at step*(l+1)
   // Manual reset from the control side is ORed on top
   always_comb begin
      for (int l = 0; l < N_LINKS; l++) begin
         mgt_reset_o[l] = mgt_reset_i[l] || (cnt_ext < MGT_RESET_STEP * (l + 1));
      end
   end

   // Single cycle pulse, the counter passes this value once per sequence
   assign txreset_o = txreset_i || (cnt_ext == TXRESET_CNT);

   // Same as counter above DONE_CNT since it saturates at DONE_CNT+1
   assign startup_done_o = (startup_cnt == CNT_TOP);

endmodule

`default_nettype wire

// File: source/link_ready_timer.sv
`timescale 1ns/10ps
`default_nettype none

module link_ready_timer #(
   parameter int unsigned N_LINKS = 4,
   parameter int unsigned READY_CNT_MAX = 50
) (
   input  logic               clock_40,
   input  logic               arst_n_i,
   input  logic [N_LINKS-1:0] txfsm_done_i,
   input  logic [N_LINKS-1:0] pll_lock_i,
   input  logic               force_not_ready_i,
   output logic               links_ready_o,
   output logic               ready_o,
   output logic               pll_lock_o,
   output logic               txfsm_done_o
);

   localparam int unsigned CNT_W = $clog2(READY_CNT_MAX + 1);
   localparam logic [CNT_W-1:0] CNT_TOP = CNT_W'(READY_CNT_MAX);

   logic [CNT_W-1:0] ready_cnt;

   // Status summary, every link must report
   assign pll_lock_o = &pll_lock_i;
   assign txfsm_done_o = &txfsm_done_i;

   // --------------------
   // Link readiness
   // --------------------

   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         links_ready_o <= 1'b0;
      end else begin
         links_ready_o <= pll_lock_o && txfsm_done_o;
      end
   end

   // --------------------
   // Hold-off timer
   // --------------------

   // Restarts from zero on any loss of ready or a forced drop
   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ready_cnt <= '0;
      end else if (!links_ready_o || force_not_ready_i) begin
         ready_cnt <= '0;
      end else if (ready_cnt != CNT_TOP) begin
         ready_cnt <= ready_cnt + 1'b1;
      end
   end

   assign ready_o = (ready_cnt == CNT_TOP);

endmodule

`default_nettype wire

// File: source/frame_sep_gen.sv
`timescale 1ns/10ps
`default_nettype none

module frame_sep_gen #(
   parameter int unsigned N_LINKS = 4,
   parameter int unsigned ALLOW_TTC_CHARS = 1
) (
   input  logic                 bc0_i,
   input  logic                 resync_i,
   input  logic [1:0]           overflow_i,
   input  logic [1:0]           bxn_lsbs_i,
   output wire  [N_LINKS*8-1:0] sep_char_o
);
   import gem_link_pkg::*;

   localparam bit TTC_EN = (ALLOW_TTC_CHARS != 0);

   logic [7:0] seq_char;

   // Rotating bunch sequence code, shared by all links
   always_comb begin
      case (bxn_lsbs_i)
         2'd0: seq_char = K_SEQ0;
         2'd1: seq_char = K_SEQ1;
         2'd2: seq_char = K_SEQ2;
         default: seq_char = K_SEQ3;
      endcase
   end

   // --------------------
   // Per-link priority
   // --------------------

   for (genvar l = 0; l < N_LINKS; l++) begin : g_link
      logic [7:0] sep;

      // BC0 first, then resync, then this half's overflow
      // Odd links carry the upper half, so they see overflow_i[1]
      always_comb begin
         if (TTC_EN && bc0_i) begin
            sep = K_BC0;
         end else if (TTC_EN && resync_i) begin
            sep = K_RESYNC;
         end else if (TTC_EN && overflow_i[l % 2]) begin
            sep = K_OVERFLOW;
         end else begin
            sep = seq_char;
         end
      end

      assign sep_char_o[8*l +: 8] = sep;
   end

endmodule

`default_nettype wire

// File: source/link_framer.sv
`timescale 1ns/10ps
`default_nettype none

module link_framer #(
   parameter int unsigned N_LINKS = 4
) (
   input  logic                                    clock_40,
   input  logic                                    arst_n_i,
   input  logic                                    links_ready_i,
   input  logic [2*gem_link_pkg::PAYLOAD_W-1:0]    gem_data_i,
   input  logic [N_LINKS*8-1:0]                    sep_char_i,
   output wire  [N_LINKS*gem_link_pkg::WORD_W-1:0] tx_data_o,
   output wire  [N_LINKS*gem_link_pkg::K_W-1:0]    tx_isk_o
);
   import gem_link_pkg::*;

   localparam logic [FRAME_IDX_W-1:0] LAST_IDX = FRAME_IDX_W'(WORDS_PER_FRAME - 1);

   logic [FRAME_IDX_W-1:0] frame_idx;

   // --------------------
   // Frame word index
   // --------------------

   // Held at word 0 while down so the first frame starts with a lead word
   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         frame_idx <= '0;
      end else if (!links_ready_i || frame_idx == LAST_IDX) begin
         frame_idx <= '0;
      end else begin
         frame_idx <= frame_idx + 1'b1;
      end
   end

   // --------------------
   // Per-link words
   // --------------------

   for (genvar l = 0; l < N_LINKS; l++) begin : g_link
      logic [PAYLOAD_W-1:0] link_data;
      logic [PAYLOAD_W-1:8] cap_q;
      tx_word_t word_d;
      tx_word_t word_q;
      logic [K_W-1:0] isk_d;
      logic [K_W-1:0] isk_q;

      // Even links take the lower cluster packet, odd links the upper
      if (l % 2 == 0) begin : g_even
         assign link_data = gem_data_i[PAYLOAD_W-1:0];
      end else begin : g_odd
         assign link_data = gem_data_i[2*PAYLOAD_W-1:PAYLOAD_W];
      end

      // Rest of the packet is held for words 1 to 3
      always_ff @(posedge clock_40) begin
         if (links_ready_i && frame_idx == '0) begin
            cap_q <= link_data[PAYLOAD_W-1:8];
         end
      end

      always_comb begin
         word_d.raw = IDLE_WORD;
         isk_d = K_FLAGS_LEAD;
         if (links_ready_i) begin
            case (frame_idx)
               2'd0: begin
                  // Live payload byte above the separator K char
                  word_d.lead.payload = link_data[7:0];
                  word_d.lead.sep = sep_char_i[8*l +: 8];
               end
               2'd1: begin
                  word_d.raw = cap_q[23:8];
                  isk_d = K_FLAGS_DATA;
               end
               2'd2: begin
                  word_d.raw = cap_q[39:24];
                  isk_d = K_FLAGS_DATA;
               end
               default: begin
                  word_d.raw = cap_q[55:40];
                  isk_d = K_FLAGS_DATA;
               end
            endcase
         end
      end

      always_ff @(posedge clock_40 or negedge arst_n_i) begin
         if (!arst_n_i) begin
            word_q.raw <= IDLE_WORD;
            isk_q <= K_FLAGS_LEAD;
         end else begin
            word_q <= word_d;
            isk_q <= isk_d;
         end
      end

      assign tx_data_o[WORD_W*l +: WORD_W] = word_q.raw;
      assign tx_isk_o[K_W*l +: K_W] = isk_q;
   end

endmodule

`default_nettype wire

// File: source/gem_link_tx.sv
`timescale 1ns/10ps
`default_nettype none

module gem_link_tx #(
   parameter int unsigned N_LINKS = 4,
   parameter int unsigned MGT_RESET_STEP = 20,
   parameter int unsigned TXRESET_CNT = 110,
   parameter int unsigned DONE_CNT = 130,
   parameter int unsigned ALLOW_RETRY = 0,
   parameter int unsigned READY_CNT_MAX = 50,
   parameter int unsigned ALLOW_TTC_CHARS = 1
) (
   input  wire                                     clock_40,
   input  wire                                     arst_n_i,
   // Cluster data, two 56 bit packets
   input  wire  [2*gem_link_pkg::PAYLOAD_W-1:0]    gem_data_i,
   input  wire  [1:0]                              overflow_i,
   // TTC side
   input  wire  [11:0]                             bxn_counter_i,
   input  wire                                     bc0_i,
   input  wire                                     resync_i,
   // Manual resets
   input  wire  [N_LINKS-1:0]                      mgt_reset_i,
   input  wire                                     txreset_i,
   // Transceiver status
   input  wire  [N_LINKS-1:0]                      txfsm_done_i,
   input  wire  [N_LINKS-1:0]                      pll_lock_i,
   input  wire                                     force_not_ready_i,
   output wire  [N_LINKS*gem_link_pkg::WORD_W-1:0] tx_data_o,
   output wire  [N_LINKS*gem_link_pkg::K_W-1:0]    tx_isk_o,
   output wire  [N_LINKS-1:0]                      mgt_reset_o,
   output wire                                     txreset_o,
   output wire                                     startup_done_o,
   output wire                                     ready_o,
   output wire                                     pll_lock_o,
   output wire                                     txfsm_done_o
);

   // Registered all-links-up, framer enable and retry qualifier
   logic links_ready;
   // One separator byte per link
   logic [N_LINKS*8-1:0] sep_char;

   // --------------------
   // Startup and ready
   // --------------------

   link_startup_seq #(
      .N_LINKS        (N_LINKS),
      .MGT_RESET_STEP (MGT_RESET_STEP),
      .TXRESET_CNT    (TXRESET_CNT),
      .DONE_CNT       (DONE_CNT),
      .ALLOW_RETRY    (ALLOW_RETRY)
   ) u_startup (
      .clock_40       (clock_40),
      .arst_n_i       (arst_n_i),
      .mgt_reset_i    (mgt_reset_i),
      .txreset_i      (txreset_i),
      .links_ready_i  (links_ready),
      .mgt_reset_o    (mgt_reset_o),
      .txreset_o      (txreset_o),
      .startup_done_o (startup_done_o)
   );

   link_ready_timer #(
      .N_LINKS           (N_LINKS),
      .READY_CNT_MAX     (READY_CNT_MAX)
   ) u_ready (
      .clock_40          (clock_40),
      .arst_n_i          (arst_n_i),
      .txfsm_done_i      (txfsm_done_i),
      .pll_lock_i        (pll_lock_i),
      .force_not_ready_i (force_not_ready_i),
      .links_ready_o     (links_ready),
      .ready_o           (ready_o),
      .pll_lock_o        (pll_lock_o),
      .txfsm_done_o      (txfsm_done_o)
   );

   // --------------------
   // Separator and framer
   // --------------------

   frame_sep_gen #(
      .N_LINKS         (N_LINKS),
      .ALLOW_TTC_CHARS (ALLOW_TTC_CHARS)
   ) u_sep (
      .bc0_i           (bc0_i),
      .resync_i        (resync_i),
      .overflow_i      (overflow_i),
      // Only the two LSBs select the bunch sequence code
      .bxn_lsbs_i      (bxn_counter_i[1:0]),
      .sep_char_o      (sep_char)
   );

   link_framer #(
      .N_LINKS       (N_LINKS)
   ) u_framer (
      .clock_40      (clock_40),
      .arst_n_i      (arst_n_i),
      .links_ready_i (links_ready),
      .gem_data_i    (gem_data_i),
      .sep_char_i    (sep_char),
      .tx_data_o     (tx_data_o),
      .tx_isk_o      (tx_isk_o)
   );

endmodule

`default_nettype wire

// File: tb/gem_link_tx_sva.sv
`timescale 1ns/10ps
`default_nettype none

module gem_link_tx_sva #(
   parameter int unsigned N_LINKS = 4
) (
   input wire                 clock_40,
   input wire                 arst_n_i,
   input wire                 txreset_i,
   input wire                 txreset_o,
   input wire [N_LINKS*2-1:0] tx_isk_o
);

   // --------------------
   // Startup outputs
   // --------------------

   // Counter driven tx reset is a single cycle pulse
   a_txreset_single : assert property (
      @(posedge clock_40) disable iff (!arst_n_i)
      (txreset_o && !txreset_i) |=> (!txreset_o || txreset_i)
   ) else $error("txreset_o high for two cycles without a manual tx reset");

   // --------------------
   // Framer outputs
   // --------------------

   // Only the lead word and idle carry a K char, always in the low byte
   for (genvar l = 0; l < N_LINKS; l++) begin : g_isk
      a_isk_legal : assert property (
         @(posedge clock_40) disable iff (!arst_n_i)
         (tx_isk_o[2*l +: 2] == 2'b01) || (tx_isk_o[2*l +: 2] == 2'b00)
      ) else $error("tx_isk_o of link %0d holds illegal flags %b", l, tx_isk_o[2*l +: 2]);
   end

endmodule

bind gem_link_tx gem_link_tx_sva #(
   .N_LINKS (N_LINKS)
) u_sva (
   .clock_40  (clock_40),
   .arst_n_i  (arst_n_i),
   .txreset_i (txreset_i),
   .txreset_o (txreset_o),
   .tx_isk_o  (tx_isk_o)
);

`default_nettype wire

// File: tb/tb_gem_link_tx.sv
`timescale 1ns/10ps
`default_nettype none

module tb_gem_link_tx;

   // DUT configuration for simulation
   localparam int N_LINKS = 4;
   localparam int MGT_RESET_STEP = 20;
   localparam int TXRESET_CNT = 110;
   localparam int DONE_CNT = 130;
   localparam int ALLOW_RETRY = 1;
   localparam int READY_CNT_MAX = 50;
   localparam int ALLOW_TTC_CHARS = 1;
   localparam int PAYLOAD_W = 56;
   localparam int WORD_W = 16;
   localparam int K_W = 2;
   localparam logic [WORD_W-1:0] IDLE = 16'hFFFC;

   // Run length, two startup sequences plus traffic and margin
   localparam int RANDOM_CYCLES = 1000;
   localparam int TAIL_CYCLES = 200;
   localparam int SEQ_CYCLES = DONE_CNT + 2 + READY_CNT_MAX;
   localparam int TIMEOUT_CYCLES = 3 * (2 * SEQ_CYCLES + RANDOM_CYCLES + TAIL_CYCLES) / 2;

   logic clock_40 = 1'b0;
   logic arst_n_i;
   logic [2*PAYLOAD_W-1:0] gem_data_i;
   logic [1:0] overflow_i;
   logic [11:0] bxn_counter_i;
   logic bc0_i;
   logic resync_i;
   logic [N_LINKS-1:0] mgt_reset_i;
   logic txreset_i;
   logic [N_LINKS-1:0] txfsm_done_i;
   logic [N_LINKS-1:0] pll_lock_i;
   logic force_not_ready_i;
   wire [N_LINKS*WORD_W-1:0] tx_data_o;
   wire [N_LINKS*K_W-1:0] tx_isk_o;
   wire [N_LINKS-1:0] mgt_reset_o;
   wire txreset_o;
   wire startup_done_o;
   wire ready_o;
   wire pll_lock_o;
   wire txfsm_done_o;

   // Bookkeeping
   int err_cnt = 0;
   int check_cnt = 0;
   int flow_err_cnt;
   int txreset_seen = 0;
   int cyc = 0;
   logic check_en;
   logic [31:0] rng_state;
   // Stimulus controls for the status inputs
   logic status_ok;
   logic pulse_force;
   logic [N_LINKS-1:0] drop_mask;
   // Random manual resets on top of the counter decodes
   logic manual_en;

   // Reference model state
   int m_cnt;
   int m_ready_cnt;
   int m_idx;
   logic m_lr;
   logic [WORD_W-1:0] m_word [N_LINKS];
   logic [K_W-1:0] m_isk [N_LINKS];
   logic [PAYLOAD_W-1:0] m_cap [N_LINKS];

   gem_link_tx #(
      .N_LINKS         (N_LINKS),
      .MGT_RESET_STEP  (MGT_RESET_STEP),
      .TXRESET_CNT     (TXRESET_CNT),
      .DONE_CNT        (DONE_CNT),
      .ALLOW_RETRY     (ALLOW_RETRY),
      .READY_CNT_MAX   (READY_CNT_MAX),
      .ALLOW_TTC_CHARS (ALLOW_TTC_CHARS)
   ) u_dut (
      .clock_40          (clock_40),
      .arst_n_i          (arst_n_i),
      .gem_data_i        (gem_data_i),
      .overflow_i        (overflow_i),
      .bxn_counter_i     (bxn_counter_i),
      .bc0_i             (bc0_i),
      .resync_i          (resync_i),
      .mgt_reset_i       (mgt_reset_i),
      .txreset_i         (txreset_i),
      .txfsm_done_i      (txfsm_done_i),
      .pll_lock_i        (pll_lock_i),
      .force_not_ready_i (force_not_ready_i),
      .tx_data_o         (tx_data_o),
      .tx_isk_o          (tx_isk_o),
      .mgt_reset_o       (mgt_reset_o),
      .txreset_o         (txreset_o),
      .startup_done_o    (startup_done_o),
      .ready_o           (ready_o),
      .pll_lock_o        (pll_lock_o),
      .txfsm_done_o      (txfsm_done_o)
   );

   // 8 ns period
   always #4 clock_40 = ~clock_40;

   // --------------------
   // Random source
   // --------------------

   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // --------------------
   // Reference model
   // --------------------

   // Even links lower packet, odd links upper packet
   function automatic logic [PAYLOAD_W-1:0] link_payload(int l);
      return (l % 2 == 0) ? gem_data_i[PAYLOAD_W-1:0] : gem_data_i[2*PAYLOAD_W-1:PAYLOAD_W];
   endfunction

   // BC0, resync, own half overflow, else rotating sequence code
   function automatic logic [7:0] expected_sep(int l);
      if (ALLOW_TTC_CHARS != 0 && bc0_i)
         return 8'h1C;
      if (ALLOW_TTC_CHARS != 0 && resync_i)
         return 8'h3C;
      if (ALLOW_TTC_CHARS != 0 && overflow_i[l % 2])
         return 8'hFC;
      case (bxn_counter_i[1:0])
         2'd0: return 8'hBC;
         2'd1: return 8'hF7;
         2'd2: return 8'hFB;
         default: return 8'hFD;
      endcase
   endfunction

   // One clock edge, all next values from the pre-edge state
   task automatic advance_model();
      int next_cnt;
      int next_rdy;
      int next_idx;
      logic [PAYLOAD_W-1:0] pl;
      if (ALLOW_RETRY != 0 && m_cnt > DONE_CNT && !m_lr)
         next_cnt = 0;
      else if (m_cnt <= DONE_CNT)
         next_cnt = m_cnt + 1;
      else
         next_cnt = m_cnt;
      if (!m_lr || force_not_ready_i)
         next_rdy = 0;
      else if (m_ready_cnt < READY_CNT_MAX)
         next_rdy = m_ready_cnt + 1;
      else
         next_rdy = m_ready_cnt;
      for (int l = 0; l < N_LINKS; l++) begin
         pl = link_payload(l);
         if (!m_lr) begin
            m_word[l] = IDLE;
            m_isk[l] = 2'b01;
         end else begin
            case (m_idx)
               0: begin
                  m_word[l] = {pl[7:0], expected_sep(l)};
                  m_isk[l] = 2'b01;
                  m_cap[l] = pl;
               end
               1: m_word[l] = m_cap[l][23:8];
               2: m_word[l] = m_cap[l][39:24];
               default: m_word[l] = m_cap[l][55:40];
            endcase
            if (m_idx != 0)
               m_isk[l] = 2'b00;
         end
      end
      next_idx = (!m_lr || m_idx == 3) ? 0 : m_idx + 1;
      m_lr = (&txfsm_done_i) && (&pll_lock_i);
      m_cnt = next_cnt;
      m_ready_cnt = next_rdy;
      m_idx = next_idx;
   endtask

   always @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         m_cnt = 0;
         m_lr = 1'b0;
         m_ready_cnt = 0;
         m_idx = 0;
         for (int l = 0; l < N_LINKS; l++) begin
            m_word[l] = IDLE;
            m_isk[l] = 2'b01;
            m_cap[l] = '0;
         end
      end else begin
         advance_model();
      end
   end

   // --------------------
   // Output checks
   // --------------------

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      check_cnt++;
      assert (got === exp) else begin
         err_cnt++;
         $display("Error: %s expected 0x%0h got 0x%0h at %0t", name, exp, got, $time);
      end
   endtask

   task automatic check_outputs();
      logic [N_LINKS-1:0] exp_rst;
      for (int l = 0; l < N_LINKS; l++) begin
         exp_rst[l] = mgt_reset_i[l] || (m_cnt < MGT_RESET_STEP * (l + 1));
      end
      compare_value("mgt_reset_o", 32'(mgt_reset_o), 32'(exp_rst));
      compare_value("txreset_o", 32'(txreset_o), 32'(txreset_i || m_cnt == TXRESET_CNT));
      compare_value("startup_done_o", 32'(startup_done_o), 32'(m_cnt > DONE_CNT));
      compare_value("ready_o", 32'(ready_o), 32'(m_ready_cnt == READY_CNT_MAX));
      compare_value("pll_lock_o", 32'(pll_lock_o), 32'(&pll_lock_i));
      compare_value("txfsm_done_o", 32'(txfsm_done_o), 32'(&txfsm_done_i));
      for (int l = 0; l < N_LINKS; l++) begin
         compare_value($sformatf("tx_data_o[%0d]", l),
                       32'(tx_data_o[WORD_W*l +: WORD_W]), 32'(m_word[l]));
         compare_value($sformatf("tx_isk_o[%0d]", l),
                       32'(tx_isk_o[K_W*l +: K_W]), 32'(m_isk[l]));
      end
   endtask

   // Outputs only move at the rising edge, sample on the falling one
   always @(negedge clock_40) begin
      if (check_en) begin
         check_outputs();
         // Counter driven pulses only
         if (arst_n_i && txreset_o && !txreset_i)
            txreset_seen++;
      end
   end

   always @(posedge clock_40) begin
      cyc++;
      if (cyc >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the test sequence never finished", cyc);
         $display("Simulation failed");
         $finish;
      end
   end

   // --------------------
   // Stimulus
   // --------------------

   // One cycle of random traffic, returns once outputs have settled
   task automatic step();
      logic [31:0] r0;
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] r3;
      logic [31:0] ctl;
      @(posedge clock_40);
      r0 = next_random();
      r1 = next_random();
      r2 = next_random();
      r3 = next_random();
      ctl = next_random();
      gem_data_i <= {r3[15:0], r2, r1, r0};
      // TTC chars rare enough that overflow and sequence codes show up
      bc0_i <= (ctl[3:0] == 4'd0);
      resync_i <= (ctl[7:4] == 4'd0);
      overflow_i <= {ctl[10] & ctl[11], ctl[8] & ctl[9]};
      bxn_counter_i <= ctl[23:12];
      force_not_ready_i <= pulse_force;
      // Manual resets stay low during the startup sequences
      mgt_reset_i <= manual_en ? (r3[24 +: N_LINKS] & r3[28 +: N_LINKS]) : '0;
      txreset_i <= manual_en && (ctl[27:24] == 4'd0);
      if (status_ok) begin
         pll_lock_i <= '1;
         txfsm_done_i <= ~drop_mask;
      end else begin
         // Link 0 never done, so status is never all high
         pll_lock_i <= r3[16 +: N_LINKS];
         txfsm_done_i <= {r3[20 +: N_LINKS-1], 1'b0};
      end
      @(negedge clock_40);
   endtask

   initial begin
      int wait_cnt;
      arst_n_i = 1'b0;
      gem_data_i = '0;
      overflow_i = '0;
      bxn_counter_i = '0;
      bc0_i = 1'b0;
      resync_i = 1'b0;
      mgt_reset_i = '0;
      txreset_i = 1'b0;
      txfsm_done_i = '0;
      pll_lock_i = '0;
      force_not_ready_i = 1'b0;
      flow_err_cnt = 0;
      rng_state = 32'd63;
      status_ok = 1'b0;
      pulse_force = 1'b0;
      drop_mask = '0;
      manual_en = 1'b0;
      check_en = 1'b0;

      // Two cycles of reset
      @(posedge clock_40);
      check_en <= 1'b1;
      @(posedge clock_40);
      arst_n_i <= 1'b1;
      @(negedge clock_40);

      // Startup with links down, status comes up after the tx reset pulse
      do step(); while (!txreset_o);
      status_ok = 1'b1;
      do step(); while (!startup_done_o);
      assert (txreset_seen == 1) else begin
         flow_err_cnt++;
         $display("txreset_o pulsed %0d times in the first startup instead of once",
                  txreset_seen);
      end

      // Random framing with two forced ready drops and manual resets
      manual_en = 1'b1;
      for (int i = 0; i < RANDOM_CYCLES; i++) begin
         pulse_force = (i == 300) || (i == 700);
         step();
      end
      pulse_force = 1'b0;
      manual_en = 1'b0;

      // --------------------
      // Retry after link loss
      // --------------------
      drop_mask[1] = 1'b1;
      step();
      wait_cnt = 0;
      while (startup_done_o && wait_cnt < 2) begin
         step();
         wait_cnt++;
      end
      assert (!startup_done_o && mgt_reset_o == '1) else begin
         flow_err_cnt++;
         $display("Startup did not restart within two edges after link 1 dropped");
      end
      do step(); while (!txreset_o);
      drop_mask = '0;
      do step(); while (!startup_done_o);
      assert (txreset_seen == 2) else begin
         flow_err_cnt++;
         $display("txreset_o pulsed %0d times over two startups instead of twice",
                  txreset_seen);
      end
      repeat (TAIL_CYCLES) step();

      $display("Checks: %0d  output errors: %0d  sequence errors: %0d",
               check_cnt, err_cnt, flow_err_cnt);
      if (err_cnt == 0 && flow_err_cnt == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: gem_link_tx.f
source/gem_link_pkg.sv
source/link_startup_seq.sv
source/link_ready_timer.sv
source/frame_sep_gen.sv
source/link_framer.sv
source/gem_link_tx.sv
tb/gem_link_tx_sva.sv
tb/tb_gem_link_tx.sv

// File: Makefile
# Verilator build and run for the GEM trigger-link transmit framer

VERILATOR  ?= verilator
TOP        ?= tb_gem_link_tx
FILELIST   ?= gem_link_tx.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG   ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
